// ==== Bender.yml ====
package:
  name: sample_buffer

sources:
  - files:
      - design/sample_buffer_pkg.sv
      - design/sample_stream_if.sv
      - design/capture_control.sv
      - design/bank_allocator.sv
      - design/sample_bank.sv
      - design/bank_readout_mux.sv
      - design/sample_buffer.sv
  - target: test
    files:
      - test/sample_buffer_tb.sv

// ==== design/bank_allocator.sv ====
`timescale 1ns/1ns

module bank_allocator import sample_buffer_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  bank_mode_t            mode,
  input  capture_state_t        state,
  input  logic [n_channels-1:0] in_valid,
  input  sample_t               in_data [n_channels],
  output logic [n_channels-1:0] in_ready,
  input  logic                  clear_banks,
  input  logic [n_banks-1:0]    bank_full,
  sample_stream_if.source       write [n_banks],
  output logic                  capture_full
);

  bank_step_t            step;
  bank_index_t           cur_bank [n_channels];
  bank_step_t            next_bank [n_channels];
  logic [n_channels-1:0] active;
  logic [n_channels-1:0] last_bank_full;
  logic [n_banks-1:0]    bank_ready;
  logic                  accepting;

  assign step = bank_step(mode);

  // one exhausted channel ends the capture for everyone
  assign capture_full = (state == capture) && (|last_bank_full);

  // in_ready drops in the same cycle capture_full rises
  assign accepting = (state == capture) && !capture_full;

  for (genvar c = 0; c < n_channels; c++) begin : g_channel
    // channels 0 to 2^mode-1 take part
    assign active[c] = bank_step_t'(c) < step;
    assign next_bank[c] = bank_step_t'(cur_bank[c]) + step;

    // current bank full and no further bank left for this channel
    assign last_bank_full[c] = active[c] && bank_full[cur_bank[c]] &&
                               (next_bank[c] >= bank_step_t'(n_banks));

    assign in_ready[c] = accepting && active[c] && bank_ready[cur_bank[c]];
  end

  for (genvar b = 0; b < n_banks; b++) begin : g_bank
    channel_t owner;

    assign owner = bank_owner(bank_index_t'(b), mode);
    assign bank_ready[b] = write[b].ready;

    // only the owner's current bank sees its samples
    assign write[b].valid = accepting && in_valid[owner] &&
                            (cur_bank[owner] == bank_index_t'(b));
    assign write[b].data = in_data[owner];
    assign write[b].last = 1'b0;
  end

  // each channel starts in its own bank and steps by 2^mode once it fills
  always_ff @(posedge clk) begin
    for (int c = 0; c < n_channels; c++) begin
      if (reset || clear_banks) begin
        cur_bank[c] <= bank_index_t'(c);
      end else if ((state == capture) && active[c] && bank_full[cur_bank[c]] &&
                   (next_bank[c] < bank_step_t'(n_banks))) begin
        cur_bank[c] <= bank_index_t'(next_bank[c]);
      end
    end
  end

endmodule

// ==== design/bank_readout_mux.sv ====
`timescale 1ns/1ns

module bank_readout_mux import sample_buffer_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  bank_mode_t         mode,
  input  capture_state_t     state,
  output logic [n_banks-1:0] start_read,
  sample_stream_if.sink      read [n_banks],
  output logic               out_valid,
  output sample_t            out_data,
  output logic               out_last,
  input  logic               out_ready,
  output logic               readout_done
);

  typedef enum logic [1:0] {
    mux_idle,
    mux_channel,
    mux_bank
  } mux_phase_t;

  mux_phase_t         phase;
  bank_index_t        cur_bank;
  logic [n_banks-1:0] bank_valid;
  logic [n_banks-1:0] bank_last;
  sample_t            bank_data [n_banks];
  logic               final_bank;
  logic               bank_done;

  for (genvar b = 0; b < n_banks; b++) begin : g_bank
    assign bank_valid[b] = read[b].valid;
    assign bank_data[b] = read[b].data;
    assign bank_last[b] = read[b].last;
    assign read[b].ready = (phase == mux_bank) && (cur_bank == bank_index_t'(b)) && out_ready;
    // bank starts as its channel word leaves
    assign start_read[b] = (phase == mux_channel) && (cur_bank == bank_index_t'(b)) &&
                           out_ready;
  end

  assign final_bank = (cur_bank == bank_index_t'(n_banks - 1));
  assign bank_done = (phase == mux_bank) && out_ready && bank_valid[cur_bank] &&
                     bank_last[cur_bank];
  assign readout_done = bank_done && final_bank;

  always_comb begin
    out_valid = 1'b0;
    out_data = bank_data[cur_bank];
    out_last = 1'b0;
    if (phase == mux_channel) begin
      out_valid = 1'b1;
      out_data = sample_t'(bank_owner(cur_bank, mode));
    end else if (phase == mux_bank) begin
      out_valid = bank_valid[cur_bank];
      // per-bank last is only passed on for the final bank
      out_last = final_bank && bank_last[cur_bank];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= mux_idle;
      cur_bank <= '0;
    end else begin
      case (phase)
        mux_idle: begin
          if (state == readout) begin
            phase <= mux_channel;
            cur_bank <= '0;
          end
        end
        mux_channel: begin
          if (out_ready) begin
            phase <= mux_bank;
          end
        end
        mux_bank: begin
          if (bank_done) begin
            if (final_bank) begin
              phase <= mux_idle;
            end else begin
              phase <= mux_channel;
              cur_bank <= cur_bank + 1'b1;
            end
          end
        end
        default: begin
          phase <= mux_idle;
        end
      endcase
    end
  end

endmodule

// ==== design/capture_control.sv ====
`timescale 1ns/1ns

module capture_control import sample_buffer_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           config_valid,
  input  logic           config_start,
  input  logic           config_stop,
  input  bank_mode_t     config_mode,
  output logic           config_ready,
  output bank_mode_t     mode,
  output capture_state_t state,
  output logic           clear_banks,
  input  logic           capture_full,
  input  logic           readout_done
);

  logic config_fire;

  // commands are refused while the banks drain
  assign config_ready = (state != readout);
  assign config_fire = config_valid && config_ready;

  // start wipes the bank counters on the same edge that enters capture
  assign clear_banks = config_fire && config_start && (state == idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      mode <= '0;
    end else begin
      case (state)
        idle: begin
          if (config_fire && config_start) begin
            // out of range modes fall back to one bank per channel
            mode <= (config_mode > max_mode) ? max_mode : config_mode;
            state <= capture;
          end
        end
        capture: begin
          if ((config_fire && config_stop) || capture_full) begin
            state <= readout;
          end
        end
        readout: begin
          if (readout_done) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

// ==== design/sample_bank.sv ====
`timescale 1ns/1ns

module sample_bank import sample_buffer_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          clear_banks,
  sample_stream_if.sink write,
  output logic          full,
  input  logic          start_read,
  sample_stream_if.source read
);

  sample_t     mem [bank_depth];
  bank_count_t count;
  bank_count_t last_addr;
  bank_count_t rd_addr;
  logic        write_fire;
  logic        sending;
  logic        advance;

  // write side

  assign full = (count == bank_count_t'(bank_depth));
  assign write.ready = !full;
  assign write_fire = write.valid && write.ready;

  always_ff @(posedge clk) begin
    if (reset || clear_banks) begin
      count <= '0;
    end else if (write_fire) begin
      count <= count + 1'b1;
    end
  end

  // samples land at the current count
  always_ff @(posedge clk) begin
    if (write_fire) begin
      mem[count[bank_addr_width-1:0]] <= write.data;
    end
  end

  // read side

  // only meaningful while sending, which needs a nonzero count
  assign last_addr = count - 1'b1;

  // output register is free or being emptied this cycle
  assign advance = read.ready || !read.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      read.valid <= 1'b0;
      read.last <= 1'b0;
      sending <= 1'b0;
      rd_addr <= '0;
    end else if (start_read) begin
      // count word goes out first, and is also last for an empty bank
      read.valid <= 1'b1;
      read.last <= (count == '0);
      sending <= (count != '0);
      rd_addr <= '0;
    end else if (advance) begin
      if (sending) begin
        read.valid <= 1'b1;
        read.last <= (rd_addr == last_addr);
        sending <= (rd_addr != last_addr);
        rd_addr <= rd_addr + 1'b1;
      end else begin
        read.valid <= 1'b0;
        read.last <= 1'b0;
      end
    end
  end

  // registered memory read straight into the output word
  always_ff @(posedge clk) begin
    if (start_read) begin
      read.data <= sample_t'(count);
    end else if (advance && sending) begin
      read.data <= mem[rd_addr[bank_addr_width-1:0]];
    end
  end

endmodule

// ==== design/sample_buffer.sv ====
`timescale 1ns/1ns

module sample_buffer import sample_buffer_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [n_channels-1:0] in_valid,
  input  sample_t               in_data [n_channels],
  output logic [n_channels-1:0] in_ready,
  input  logic                  config_valid,
  input  logic                  config_start,
  input  logic                  config_stop,
  input  bank_mode_t            config_mode,
  output logic                  config_ready,
  output logic                  out_valid,
  input  logic                  out_ready,
  output sample_t               out_data,
  output logic                  out_last
);

  bank_mode_t         mode;
  capture_state_t     state;
  logic               clear_banks;
  logic               capture_full;
  logic               readout_done;
  logic [n_banks-1:0] bank_full;
  logic [n_banks-1:0] start_read;

  sample_stream_if write_bus [n_banks] ();
  sample_stream_if read_bus [n_banks] ();

  capture_control u_control (
    .clk,
    .reset,
    .config_valid,
    .config_start,
    .config_stop,
    .config_mode,
    .config_ready,
    .mode,
    .state,
    .clear_banks,
    .capture_full,
    .readout_done
  );

  bank_allocator u_allocator (
    .clk,
    .reset,
    .mode,
    .state,
    .in_valid,
    .in_data,
    .in_ready,
    .clear_banks,
    .bank_full,
    .write        (write_bus),
    .capture_full
  );

  for (genvar b = 0; b < n_banks; b++) begin : g_bank
    sample_bank u_bank (
      .clk,
      .reset,
      .clear_banks,
      .write      (write_bus[b]),
      .full       (bank_full[b]),
      .start_read (start_read[b]),
      .read       (read_bus[b])
    );
  end

  bank_readout_mux u_readout (
    .clk,
    .reset,
    .mode,
    .state,
    .start_read,
    .read         (read_bus),
    .out_valid,
    .out_data,
    .out_last,
    .out_ready,
    .readout_done
  );

endmodule

// ==== design/sample_buffer_pkg.sv ====
package sample_buffer_pkg;

  localparam int n_channels = 4;
  localparam int n_banks = 4;
  localparam int bank_depth = 64;
  localparam int sample_width = 16;

  // address bits inside one bank
  localparam int bank_addr_width = $clog2(bank_depth);

  typedef logic [sample_width-1:0] sample_t;

  // one extra bit so a full bank can report 64
  typedef logic [bank_addr_width:0] bank_count_t;
  typedef logic [$clog2(n_banks)-1:0] bank_index_t;
  typedef logic [$clog2(n_channels)-1:0] channel_t;
  typedef logic [1:0] bank_mode_t;

  // distance between two banks of one channel, up to n_banks
  typedef logic [$clog2(n_banks):0] bank_step_t;

  localparam bank_mode_t max_mode = 2'd2;

  typedef enum logic [1:0] {
    idle,
    capture,
    readout
  } capture_state_t;

  // banks of one channel are spaced 2^mode apart
  function automatic bank_step_t bank_step(bank_mode_t mode);
    return bank_step_t'(1) << mode;
  endfunction

  // channel that owns a bank in the given mode
  function automatic channel_t bank_owner(bank_index_t bank, bank_mode_t mode);
    return channel_t'(bank) & channel_t'(bank_step(mode) - 1'b1);
  endfunction

endpackage

// ==== design/sample_stream_if.sv ====
`timescale 1ns/1ns

interface sample_stream_if import sample_buffer_pkg::*; ();

  logic    valid;
  logic    ready;
  sample_t data;
  logic    last;

  // producer side
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

// ==== sample_buffer.f ====
design/sample_buffer_pkg.sv
design/sample_stream_if.sv
design/capture_control.sv
design/bank_allocator.sv
design/sample_bank.sv
design/bank_readout_mux.sv
design/sample_buffer.sv
test/sample_buffer_tb.sv

// ==== test/sample_buffer_cases.txt ====
# mode samples_per_channel gap_flag ready_toggle_flag count_bank0 count_bank1 count_bank2 count_bank3
# gap_flag drops in_valid at random, ready_toggle_flag toggles out_ready at random
0 5 0 0 5 0 0 0
1 5 0 0 5 5 0 0
2 5 0 0 5 5 5 5
0 0 0 0 0 0 0 0
1 0 0 1 0 0 0 0
2 0 1 1 0 0 0 0
0 64 0 0 64 0 0 0
0 70 0 0 64 6 0 0
1 100 0 0 64 64 36 36
1 70 0 1 64 64 6 6
2 40 1 0 40 40 40 40
2 40 1 1 40 40 40 40
0 150 1 1 64 64 22 0
1 127 1 0 64 64 63 63
2 3 1 1 3 3 3 3
2 64 0 0 64 64 64 64
2 70 0 1 64 64 64 64
1 140 0 0 64 64 64 64
0 300 0 0 64 64 64 64
0 300 1 1 64 64 64 64

// ==== test/sample_buffer_tb.sv ====
`timescale 1ns/1ns

module sample_buffer_tb import sample_buffer_pkg::*; ();

  localparam int max_wait = 4000;

  logic                  clk;
  logic                  reset;
  logic [n_channels-1:0] in_valid;
  sample_t               in_data [n_channels];
  logic [n_channels-1:0] in_ready;
  logic                  config_valid;
  logic                  config_start;
  logic                  config_stop;
  bank_mode_t            config_mode;
  logic                  config_ready;
  logic                  out_valid;
  logic                  out_ready;
  sample_t               out_data;
  logic                  out_last;

  int      seed;
  int      n_cases;
  int      case_mode;
  int      case_samples;
  int      case_gap;
  int      case_toggle;
  int      case_count [n_banks];
  // every sample the DUT took, per channel in arrival order
  sample_t accepted [n_channels][n_banks*bank_depth];
  int      n_accepted [n_channels];

  sample_buffer dut (.*);

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_sample(string name, sample_t expected, sample_t actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(string name, bank_count_t expected, bank_count_t actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_channel(string name, channel_t expected, channel_t actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s expected %b got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_config(logic start, logic stop, bank_mode_t mode);
    int waited;
    waited = 0;
    config_valid = 1'b1;
    config_start = start;
    config_stop = stop;
    config_mode = mode;
    #1;
    while (!config_ready) begin
      waited++;
      if (waited > max_wait) begin
        $display("timeout waiting for config_ready");
        abort_run();
      end
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    config_valid = 1'b0;
    config_start = 1'b0;
    config_stop = 1'b0;
  endtask

  task automatic run_capture();
    logic [n_channels-1:0] pending;
    int remaining [n_channels];
    int step;
    int waited;
    int rnd;
    int left;
    bit busy;
    step = 1 << case_mode;
    pending = '0;
    waited = 0;
    busy = 1'b1;
    for (int c = 0; c < n_channels; c++) begin
      n_accepted[c] = 0;
      remaining[c] = (c < step) ? case_samples : 0;
    end
    while (busy) begin
      for (int c = 0; c < n_channels; c++) begin
        rnd = $random(seed);
        // a presented sample stays until it is taken
        if (!pending[c] && remaining[c] > 0 && (case_gap == 0 || rnd[0])) begin
          pending[c] = 1'b1;
          in_data[c] = sample_t'($random(seed));
        end
      end
      in_valid = pending;
      #1;
      for (int c = 0; c < n_channels; c++) begin
        if (c >= step) begin
          check_flag($sformatf("in_ready[%0d]", c), 1'b0, in_ready[c]);
        end
        if (pending[c] && in_ready[c]) begin
          accepted[c][n_accepted[c]] = in_data[c];
          n_accepted[c]++;
          remaining[c]--;
          pending[c] = 1'b0;
        end
      end
      // a full channel ends the capture on its own
      left = 0;
      for (int c = 0; c < n_channels; c++) begin
        left += remaining[c];
      end
      busy = config_ready && (left != 0);
      waited++;
      if (waited > max_wait) begin
        $display("timeout waiting for the capture to end");
        abort_run();
      end
      @(negedge clk);
    end
    in_valid = '0;
    if (config_ready) begin
      send_config(1'b0, 1'b1, '0);
    end
  endtask

  task automatic run_readout();
    int step;
    int bank;
    int pos;
    int ch;
    int total;
    int waited;
    int rnd;
    bit done;
    step = 1 << case_mode;
    for (int c = 0; c < n_channels; c++) begin
      total = 0;
      for (int b = c; b < n_banks; b += step) begin
        total += (c < step) ? case_count[b] : 0;
      end
      if (total != n_accepted[c]) begin
        $display("channel %0d had %0d samples accepted but the case lists %0d",
                 c, n_accepted[c], total);
        abort_run();
      end
    end
    bank = 0;
    pos = 0;
    waited = 0;
    done = 1'b0;
    // samples offered now must all be refused
    in_valid = '1;
    while (!done) begin
      rnd = $random(seed);
      out_ready = (case_toggle == 0) || rnd[0];
      #1;
      check_flag("in_ready (any)", 1'b0, |in_ready);
      check_flag("config_ready", 1'b0, config_ready);
      if (out_valid && out_ready) begin
        ch = bank % step;
        if (pos == 0) begin
          check_channel("out_data channel", channel_t'(ch), channel_t'(out_data));
          check_sample("out_data channel upper bits", '0, out_data >> $bits(channel_t));
        end else if (pos == 1) begin
          check_count("out_data count", bank_count_t'(case_count[bank]), bank_count_t'(out_data));
          check_sample("out_data count upper bits", '0, out_data >> $bits(bank_count_t));
        end else begin
          check_sample("out_data sample", accepted[ch][(bank / step) * bank_depth + pos - 2],
                       out_data);
        end
        check_flag("out_last", (bank == n_banks - 1) && (pos == case_count[bank] + 1), out_last);
        done = out_last;
        pos++;
        if (pos == case_count[bank] + 2) begin
          bank++;
          pos = 0;
        end
      end
      waited++;
      if (waited > max_wait) begin
        $display("timeout waiting for out_last");
        abort_run();
      end
      @(negedge clk);
    end
    in_valid = '0;
    out_ready = 1'b0;
    #1;
    check_flag("config_ready", 1'b1, config_ready);
    @(negedge clk);
  endtask

  initial begin
    int    fd;
    int    n;
    string line;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = '0;
    for (int c = 0; c < n_channels; c++) begin
      in_data[c] = '0;
    end
    config_valid = 1'b0;
    config_start = 1'b0;
    config_stop = 1'b0;
    config_mode = '0;
    out_ready = 1'b0;
    seed = 32'hac00_14c3;
    n_cases = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    check_flag("in_ready (any)", 1'b0, |in_ready);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("out_last", 1'b0, out_last);
    check_flag("config_ready", 1'b1, config_ready);
    @(negedge clk);
    fd = $fopen("test/sample_buffer_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open test/sample_buffer_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %d %d %d %d %d %d %d", case_mode, case_samples, case_gap,
                    case_toggle, case_count[0], case_count[1], case_count[2], case_count[3]);
        if (n == 8) begin
          n_cases++;
          $display("case %0d: mode %0d, %0d samples per channel", n_cases, case_mode,
                   case_samples);
          send_config(1'b1, 1'b0, bank_mode_t'(case_mode));
          run_capture();
          run_readout();
        end else if (n > 0) begin
          $display("malformed line in the cases file: %s", line);
          abort_run();
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      $display("the cases file holds no cases");
      abort_run();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
